/* tcp_glue_pkg.sv */
package tcp_glue_pkg;

  localparam int DATA_WIDTH      = 512;               // fixed stream width
  localparam int KEEP_WIDTH      = DATA_WIDTH / 8;    // one enable per byte
  localparam int RX_BUFFER_DEPTH = 64;                // 1024 on hardware
  localparam int RX_PTR_WIDTH    = $clog2(RX_BUFFER_DEPTH);
  localparam int RX_OCC_WIDTH    = RX_PTR_WIDTH + 1;  // holds 0..depth
  localparam int RX_COUNT_WIDTH  = 16;                // count port of the core
  localparam int CORE_CMD_WIDTH  = 72;                // core datamover command word
  localparam int CMD_ADDR_LSB    = 32;                // address field in the core word
  localparam int CMD_ADDR_MSB    = 63;
  localparam int CMD_LEN_MSB     = 22;                // length field, 23 bits from bit 0
  localparam int MEM_ADDR_WIDTH  = 64;
  localparam int MEM_LEN_WIDTH   = 32;
  localparam int STAT_WIDTH      = 16;                // tx read counters

  // one beat of a data stream
  typedef struct packed {
    logic [DATA_WIDTH-1:0] data;
    logic [KEEP_WIDTH-1:0] keep;
    logic                  last;
  } axis_beat_t;

  typedef struct packed {
    logic [MEM_ADDR_WIDTH-1:0] addr;
    logic [MEM_LEN_WIDTH-1:0]  len;  // bytes
  } mem_cmd_t;

  typedef struct packed {
    logic [15:0] port;
  } listen_port_t;

  typedef struct packed {
    logic [7:0] result;  // nonzero when port opened
  } listen_status_t;

  typedef struct packed {
    logic [31:0] ip_addr;
    logic [15:0] port;
  } open_conn_t;

  typedef struct packed {
    logic [15:0] session_id;
    logic [7:0]  success;
  } open_status_t;

  typedef struct packed {
    logic [15:0] session_id;
    logic [15:0] length;
  } read_pkg_t;

  typedef struct packed {
    logic [15:0] session_id;
    logic [15:0] length;
  } tx_meta_t;

endpackage

/* axis_reg_slice.sv */
`timescale 1ns/1ns

module axis_reg_slice
  import tcp_glue_pkg::*;
#(
  parameter type payload_t = listen_port_t
) (
  input  logic     net_clk,
  input  logic     net_aresetn,
  input  logic     s_valid,
  output logic     s_ready,
  input  payload_t s_data,
  output logic     m_valid,
  input  logic     m_ready,
  output payload_t m_data
);

  payload_t skid_data;   // second entry filled only under back-pressure
  logic     skid_valid;
  logic     s_fire;
  logic     m_free;      // output register can take a new entry

  assign s_ready = ~skid_valid;       // straight from a flop with no path from m_ready
  assign s_fire  = s_valid & s_ready;
  assign m_free  = ~m_valid | m_ready;

  always_ff @(posedge net_clk) begin
    if (!net_aresetn) begin
      m_valid    <= 1'b0;
      skid_valid <= 1'b0;
    end else begin
      if (m_free) begin
        m_valid    <= skid_valid | s_fire;  // skid drains first
        skid_valid <= 1'b0;
      end else if (s_fire) begin
        skid_valid <= 1'b1;                 // park the beat while the output is stalled
      end
    end
  end

  // payload path
  always_ff @(posedge net_clk) begin
    if (m_free) begin
      m_data <= skid_valid ? skid_data : s_data;
    end
    if (s_fire && !m_free) begin
      skid_data <= s_data;
    end
  end

  // a parked beat stays put while both entries are full and the output stalls
  a_no_overwrite: assert property (@(posedge net_clk) disable iff (!net_aresetn)
    (m_valid && skid_valid && !m_ready) |=> (skid_valid && skid_data == $past(skid_data)));

  // stalled output keeps its payload until taken
  a_hold_stalled: assert property (@(posedge net_clk) disable iff (!net_aresetn)
    (m_valid && !m_ready) |=> (m_valid && m_data == $past(m_data)));

endmodule

/* rx_buffer_fifo.sv */
`timescale 1ns/1ns

module rx_buffer_fifo
  import tcp_glue_pkg::*;
(
  input  logic                      net_clk,
  input  logic                      net_aresetn,
  input  logic                      in_valid,
  output logic                      in_ready,
  input  axis_beat_t                in_beat,
  output logic                      out_valid,
  input  logic                      out_ready,
  output axis_beat_t                out_beat,
  output logic [RX_COUNT_WIDTH-1:0] rx_count
);

  axis_beat_t              mem [RX_BUFFER_DEPTH];
  logic [RX_PTR_WIDTH-1:0] wr_ptr;
  logic [RX_PTR_WIDTH-1:0] rd_ptr;
  logic [RX_OCC_WIDTH-1:0] occ;      // beats stored now
  logic [RX_OCC_WIDTH-1:0] occ_d1;
  logic [RX_OCC_WIDTH-1:0] occ_d2;   // what the core sees
  logic                    wr_en;
  logic                    rd_en;

  assign in_ready  = (occ != RX_OCC_WIDTH'(RX_BUFFER_DEPTH));
  assign out_valid = (occ != '0);
  assign out_beat  = mem[rd_ptr];     // async read of the queue head
  assign wr_en     = in_valid & in_ready;
  assign rd_en     = out_valid & out_ready;

  // storage
  always_ff @(posedge net_clk) begin
    if (wr_en) begin
      mem[wr_ptr] <= in_beat;
    end
  end

  // pointers wrap on their own as depth is a power of two
  always_ff @(posedge net_clk) begin
    if (!net_aresetn) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      occ    <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (rd_en) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({wr_en, rd_en})
        2'b10:   occ <= occ + 1'b1;
        2'b01:   occ <= occ - 1'b1;
        default: occ <= occ;  // idle or write and read together
      endcase
    end
  end

  // two stages toward the core to meet its timing budget
  always_ff @(posedge net_clk) begin
    if (!net_aresetn) begin
      occ_d1 <= '0;
      occ_d2 <= '0;
    end else begin
      occ_d1 <= occ;
      occ_d2 <= occ_d1;
    end
  end

  assign rx_count = {{(RX_COUNT_WIDTH - RX_OCC_WIDTH){1'b0}}, occ_d2};

  // a write when full or a read when empty would take the count past depth
  a_no_overflow: assert property (@(posedge net_clk) disable iff (!net_aresetn)
    occ <= RX_OCC_WIDTH'(RX_BUFFER_DEPTH));

  // pointer distance tracks the fill level
  a_ptr_occ: assert property (@(posedge net_clk) disable iff (!net_aresetn)
    RX_PTR_WIDTH'(wr_ptr - rd_ptr) == occ[RX_PTR_WIDTH-1:0]);

endmodule

/* tx_mem_cmd_unit.sv */
`timescale 1ns/1ns

module tx_mem_cmd_unit
  import tcp_glue_pkg::*;
(
  input  logic                      net_clk,
  input  logic                      net_aresetn,
  input  logic                      core_rd_valid,
  output logic                      core_rd_ready,
  input  logic [CORE_CMD_WIDTH-1:0] core_rd_word,
  input  logic                      core_wr_valid,
  output logic                      core_wr_ready,
  input  logic [CORE_CMD_WIDTH-1:0] core_wr_word,
  output logic                      mem_rd_valid,
  input  logic                      mem_rd_ready,
  output mem_cmd_t                  mem_rd_cmd,
  output logic                      mem_wr_valid,
  input  logic                      mem_wr_ready,
  output mem_cmd_t                  mem_wr_cmd,
  input  logic                      rd_data_valid,
  input  logic                      rd_data_ready,
  input  logic                      rd_data_last,
  output logic [STAT_WIDTH-1:0]     rd_cmd_count,
  output logic [STAT_WIDTH-1:0]     rd_pkg_count
);

  // core word to address and length with a zero upper address half
  function automatic mem_cmd_t fmt_cmd(input logic [CORE_CMD_WIDTH-1:0] word);
    mem_cmd_t cmd;
    cmd.addr = {{(MEM_ADDR_WIDTH - (CMD_ADDR_MSB - CMD_ADDR_LSB + 1)){1'b0}},
                word[CMD_ADDR_MSB:CMD_ADDR_LSB]};
    cmd.len  = {{(MEM_LEN_WIDTH - CMD_LEN_MSB - 1){1'b0}}, word[CMD_LEN_MSB:0]};
    return cmd;
  endfunction

  assign mem_rd_valid  = core_rd_valid;  // handshake passes straight through
  assign core_rd_ready = mem_rd_ready;
  assign mem_rd_cmd    = fmt_cmd(core_rd_word);
  assign mem_wr_valid  = core_wr_valid;
  assign core_wr_ready = mem_wr_ready;
  assign mem_wr_cmd    = fmt_cmd(core_wr_word);

  always_ff @(posedge net_clk) begin
    if (!net_aresetn) begin
      rd_cmd_count <= '0;
      rd_pkg_count <= '0;
    end else begin
      if (mem_rd_valid && mem_rd_ready) begin
        rd_cmd_count <= rd_cmd_count + 1'b1;  // accepted read command
      end
      if (rd_data_valid && rd_data_ready && rd_data_last) begin
        rd_pkg_count <= rd_pkg_count + 1'b1;  // end of a read packet
      end
    end
  end

  // core holds a stalled read command until the memory side takes it
  a_rd_cmd_hold: assert property (@(posedge net_clk) disable iff (!net_aresetn)
    (core_rd_valid && !core_rd_ready) |=> (core_rd_valid && $stable(core_rd_word)));

  // same for a stalled write command
  a_wr_cmd_hold: assert property (@(posedge net_clk) disable iff (!net_aresetn)
    (core_wr_valid && !core_wr_ready) |=> (core_wr_valid && $stable(core_wr_word)));

endmodule

/* tcp_glue_top.sv */
`timescale 1ns/1ns

module tcp_glue_top
  import tcp_glue_pkg::*;
(
  input  logic                      net_clk,
  input  logic                      net_aresetn,
  // app to core metadata
  input  logic                      app_listen_port_valid,
  output logic                      app_listen_port_ready,
  input  listen_port_t              app_listen_port_data,
  output logic                      core_listen_port_valid,
  input  logic                      core_listen_port_ready,
  output listen_port_t              core_listen_port_data,
  input  logic                      app_open_conn_valid,
  output logic                      app_open_conn_ready,
  input  open_conn_t                app_open_conn_data,
  output logic                      core_open_conn_valid,
  input  logic                      core_open_conn_ready,
  output open_conn_t                core_open_conn_data,
  input  logic                      app_read_pkg_valid,
  output logic                      app_read_pkg_ready,
  input  read_pkg_t                 app_read_pkg_data,
  output logic                      core_read_pkg_valid,
  input  logic                      core_read_pkg_ready,
  output read_pkg_t                 core_read_pkg_data,
  input  logic                      app_tx_meta_valid,
  output logic                      app_tx_meta_ready,
  input  tx_meta_t                  app_tx_meta_data,
  output logic                      core_tx_meta_valid,
  input  logic                      core_tx_meta_ready,
  output tx_meta_t                  core_tx_meta_data,
  // core to app status
  input  logic                      core_listen_status_valid,
  output logic                      core_listen_status_ready,
  input  listen_status_t            core_listen_status_data,
  output logic                      app_listen_status_valid,
  input  logic                      app_listen_status_ready,
  output listen_status_t            app_listen_status_data,
  input  logic                      core_open_status_valid,
  output logic                      core_open_status_ready,
  input  open_status_t              core_open_status_data,
  output logic                      app_open_status_valid,
  input  logic                      app_open_status_ready,
  output open_status_t              app_open_status_data,
  // rx bypass buffer
  input  logic                      core_rx_data_valid,
  output logic                      core_rx_data_ready,
  input  axis_beat_t                core_rx_data_beat,
  output logic                      app_rx_data_valid,
  input  logic                      app_rx_data_ready,
  output axis_beat_t                app_rx_data_beat,
  output logic [RX_COUNT_WIDTH-1:0] rx_count,
  // tx memory channel
  input  logic                      core_rd_cmd_valid,
  output logic                      core_rd_cmd_ready,
  input  logic [CORE_CMD_WIDTH-1:0] core_rd_cmd_data,
  input  logic                      core_wr_cmd_valid,
  output logic                      core_wr_cmd_ready,
  input  logic [CORE_CMD_WIDTH-1:0] core_wr_cmd_data,
  output logic                      mem_rd_cmd_valid,
  input  logic                      mem_rd_cmd_ready,
  output mem_cmd_t                  mem_rd_cmd_data,
  output logic                      mem_wr_cmd_valid,
  input  logic                      mem_wr_cmd_ready,
  output mem_cmd_t                  mem_wr_cmd_data,
  input  logic                      mem_rd_data_valid,
  output logic                      mem_rd_data_ready,
  input  axis_beat_t                mem_rd_data_beat,
  output logic                      core_rd_data_valid,
  input  logic                      core_rd_data_ready,
  output axis_beat_t                core_rd_data_beat,
  output logic [STAT_WIDTH-1:0]     rd_cmd_count,
  output logic [STAT_WIDTH-1:0]     rd_pkg_count
);

  // 512-bit read data needs no width conversion
  assign core_rd_data_valid = mem_rd_data_valid;
  assign mem_rd_data_ready  = core_rd_data_ready;
  assign core_rd_data_beat  = mem_rd_data_beat;

  // slices break the comb loops between app logic and the core
  axis_reg_slice #(.payload_t(listen_port_t)) u_listen_port_slice (
    .net_clk, .net_aresetn,
    .s_valid(app_listen_port_valid), .s_ready(app_listen_port_ready),
    .s_data(app_listen_port_data), .m_valid(core_listen_port_valid),
    .m_ready(core_listen_port_ready), .m_data(core_listen_port_data));

  axis_reg_slice #(.payload_t(open_conn_t)) u_open_conn_slice (
    .net_clk, .net_aresetn,
    .s_valid(app_open_conn_valid), .s_ready(app_open_conn_ready),
    .s_data(app_open_conn_data), .m_valid(core_open_conn_valid),
    .m_ready(core_open_conn_ready), .m_data(core_open_conn_data));

  axis_reg_slice #(.payload_t(read_pkg_t)) u_read_pkg_slice (
    .net_clk, .net_aresetn,
    .s_valid(app_read_pkg_valid), .s_ready(app_read_pkg_ready),
    .s_data(app_read_pkg_data), .m_valid(core_read_pkg_valid),
    .m_ready(core_read_pkg_ready), .m_data(core_read_pkg_data));

  axis_reg_slice #(.payload_t(tx_meta_t)) u_tx_meta_slice (
    .net_clk, .net_aresetn,
    .s_valid(app_tx_meta_valid), .s_ready(app_tx_meta_ready),
    .s_data(app_tx_meta_data), .m_valid(core_tx_meta_valid),
    .m_ready(core_tx_meta_ready), .m_data(core_tx_meta_data));

  axis_reg_slice #(.payload_t(listen_status_t)) u_listen_status_slice (
    .net_clk, .net_aresetn,
    .s_valid(core_listen_status_valid), .s_ready(core_listen_status_ready),
    .s_data(core_listen_status_data), .m_valid(app_listen_status_valid),
    .m_ready(app_listen_status_ready), .m_data(app_listen_status_data));

  axis_reg_slice #(.payload_t(open_status_t)) u_open_status_slice (
    .net_clk, .net_aresetn,
    .s_valid(core_open_status_valid), .s_ready(core_open_status_ready),
    .s_data(core_open_status_data), .m_valid(app_open_status_valid),
    .m_ready(app_open_status_ready), .m_data(app_open_status_data));

  rx_buffer_fifo u_rx_buffer (
    .net_clk, .net_aresetn,
    .in_valid(core_rx_data_valid), .in_ready(core_rx_data_ready),
    .in_beat(core_rx_data_beat), .out_valid(app_rx_data_valid),
    .out_ready(app_rx_data_ready), .out_beat(app_rx_data_beat),
    .rx_count);

  tx_mem_cmd_unit u_tx_cmd (
    .net_clk, .net_aresetn,
    .core_rd_valid(core_rd_cmd_valid), .core_rd_ready(core_rd_cmd_ready),
    .core_rd_word(core_rd_cmd_data),
    .core_wr_valid(core_wr_cmd_valid), .core_wr_ready(core_wr_cmd_ready),
    .core_wr_word(core_wr_cmd_data),
    .mem_rd_valid(mem_rd_cmd_valid), .mem_rd_ready(mem_rd_cmd_ready),
    .mem_rd_cmd(mem_rd_cmd_data),
    .mem_wr_valid(mem_wr_cmd_valid), .mem_wr_ready(mem_wr_cmd_ready),
    .mem_wr_cmd(mem_wr_cmd_data),
    .rd_data_valid(mem_rd_data_valid), .rd_data_ready(core_rd_data_ready),
    .rd_data_last(mem_rd_data_beat.last),
    .rd_cmd_count, .rd_pkg_count);

endmodule

/* tb_tcp_glue.sv */
`timescale 1ns/1ns

// random traffic and in-order scoreboard for one register slice
module slice_traffic #(
  parameter int    W    = 8,
  parameter string NAME = "slice"
) (
  input  logic         net_clk,
  input  logic         net_aresetn,
  input  logic         run,        // low stops sending and drains the output
  output logic         s_valid,
  input  logic         s_ready,
  output logic [W-1:0] s_data,
  input  logic         m_valid,
  output logic         m_ready,
  input  logic [W-1:0] m_data,
  output int           errors,
  output int           pending     // accepted but not yet delivered
);

  logic [W-1:0] expect_q[$];

  initial begin
    s_valid = 1'b0;
    s_data  = '0;
    m_ready = 1'b0;
    errors  = 0;
    pending = 0;
  end

  always @(posedge net_clk) begin
    if (net_aresetn) begin
      if (s_valid && s_ready) begin
        expect_q.push_back(s_data);  // input transfer
      end
      if (m_valid && m_ready) begin
        assert (expect_q.size() != 0 && m_data == expect_q[0]) else begin
          errors++;
          $display("MISMATCH at %0t: %s delivered %h out of order", $time, NAME, m_data);
        end
        if (expect_q.size() != 0) begin
          void'(expect_q.pop_front());
        end
      end
      pending = expect_q.size();
      if (!s_valid || s_ready) begin  // hold until taken
        s_valid <= run && ($urandom % 4 != 0);
        s_data  <= W'({$urandom, $urandom});
      end
      m_ready <= !run || ($urandom % 3 != 0);  // random back-pressure
    end
  end

  // output valid of an empty slice follows an input transfer by exactly one cycle
  a_one_cycle: assert property (@(posedge net_clk) disable iff (!net_aresetn)
    !m_valid |=> (m_valid == $past(s_valid && s_ready)))
    else begin
      errors++;
      $display("ERROR at %0t: %s output valid not one cycle after input", $time, NAME);
    end

endmodule

module tb_tcp_glue
  import tcp_glue_pkg::*;
();

  logic                      net_clk = 1'b0;
  logic                      net_aresetn;
  logic                      run;        // random traffic on
  logic                      seen_full;  // buffer reported full once
  logic                      app_listen_port_valid, app_listen_port_ready;
  logic                      core_listen_port_valid, core_listen_port_ready;
  listen_port_t              app_listen_port_data, core_listen_port_data;
  logic                      app_open_conn_valid, app_open_conn_ready;
  logic                      core_open_conn_valid, core_open_conn_ready;
  open_conn_t                app_open_conn_data, core_open_conn_data;
  logic                      app_read_pkg_valid, app_read_pkg_ready;
  logic                      core_read_pkg_valid, core_read_pkg_ready;
  read_pkg_t                 app_read_pkg_data, core_read_pkg_data;
  logic                      app_tx_meta_valid, app_tx_meta_ready;
  logic                      core_tx_meta_valid, core_tx_meta_ready;
  tx_meta_t                  app_tx_meta_data, core_tx_meta_data;
  logic                      core_listen_status_valid, core_listen_status_ready;
  logic                      app_listen_status_valid, app_listen_status_ready;
  listen_status_t            core_listen_status_data, app_listen_status_data;
  logic                      core_open_status_valid, core_open_status_ready;
  logic                      app_open_status_valid, app_open_status_ready;
  open_status_t              core_open_status_data, app_open_status_data;
  logic                      core_rx_data_valid, core_rx_data_ready;
  logic                      app_rx_data_valid, app_rx_data_ready;
  axis_beat_t                core_rx_data_beat, app_rx_data_beat;
  logic [RX_COUNT_WIDTH-1:0] rx_count;
  logic                      core_rd_cmd_valid, core_rd_cmd_ready;
  logic                      core_wr_cmd_valid, core_wr_cmd_ready;
  logic [CORE_CMD_WIDTH-1:0] core_rd_cmd_data, core_wr_cmd_data;
  logic                      mem_rd_cmd_valid, mem_rd_cmd_ready;
  logic                      mem_wr_cmd_valid, mem_wr_cmd_ready;
  mem_cmd_t                  mem_rd_cmd_data, mem_wr_cmd_data;
  logic                      mem_rd_data_valid, mem_rd_data_ready;
  logic                      core_rd_data_valid, core_rd_data_ready;
  axis_beat_t                mem_rd_data_beat, core_rd_data_beat;
  logic [STAT_WIDTH-1:0]     rd_cmd_count, rd_pkg_count;
  logic [STAT_WIDTH-1:0]     rd_cmds, rd_pkgs;     // expected counter values
  axis_beat_t                rx_q[$];              // beats held by the buffer
  int                        rx_occ, occ_h1, occ_h2;
  int                        slice_err[6];
  int                        slice_pend[6];
  int                        value_errors, timeouts, waited;

  tcp_glue_top u_tcp_glue_top (.*);

  slice_traffic #(.W($bits(listen_port_t)), .NAME("listen_port")) u_lp (.net_clk, .net_aresetn,
    .run, .s_valid(app_listen_port_valid), .s_ready(app_listen_port_ready),
    .s_data(app_listen_port_data), .m_valid(core_listen_port_valid),
    .m_ready(core_listen_port_ready), .m_data(core_listen_port_data),
    .errors(slice_err[0]), .pending(slice_pend[0]));
  slice_traffic #(.W($bits(open_conn_t)), .NAME("open_conn")) u_oc (.net_clk, .net_aresetn,
    .run, .s_valid(app_open_conn_valid), .s_ready(app_open_conn_ready),
    .s_data(app_open_conn_data), .m_valid(core_open_conn_valid),
    .m_ready(core_open_conn_ready), .m_data(core_open_conn_data),
    .errors(slice_err[1]), .pending(slice_pend[1]));
  slice_traffic #(.W($bits(read_pkg_t)), .NAME("read_pkg")) u_rp (.net_clk, .net_aresetn,
    .run, .s_valid(app_read_pkg_valid), .s_ready(app_read_pkg_ready),
    .s_data(app_read_pkg_data), .m_valid(core_read_pkg_valid),
    .m_ready(core_read_pkg_ready), .m_data(core_read_pkg_data),
    .errors(slice_err[2]), .pending(slice_pend[2]));
  slice_traffic #(.W($bits(tx_meta_t)), .NAME("tx_meta")) u_tm (.net_clk, .net_aresetn,
    .run, .s_valid(app_tx_meta_valid), .s_ready(app_tx_meta_ready),
    .s_data(app_tx_meta_data), .m_valid(core_tx_meta_valid),
    .m_ready(core_tx_meta_ready), .m_data(core_tx_meta_data),
    .errors(slice_err[3]), .pending(slice_pend[3]));
  slice_traffic #(.W($bits(listen_status_t)), .NAME("listen_status")) u_ls (.net_clk,
    .net_aresetn, .run, .s_valid(core_listen_status_valid),
    .s_ready(core_listen_status_ready), .s_data(core_listen_status_data),
    .m_valid(app_listen_status_valid), .m_ready(app_listen_status_ready),
    .m_data(app_listen_status_data), .errors(slice_err[4]), .pending(slice_pend[4]));
  slice_traffic #(.W($bits(open_status_t)), .NAME("open_status")) u_os (.net_clk,
    .net_aresetn, .run, .s_valid(core_open_status_valid), .s_ready(core_open_status_ready),
    .s_data(core_open_status_data), .m_valid(app_open_status_valid),
    .m_ready(app_open_status_ready), .m_data(app_open_status_data),
    .errors(slice_err[5]), .pending(slice_pend[5]));

  always #50 net_clk = ~net_clk;  // 100 ns period

  task automatic flag_mismatch(input string what);
    value_errors++;
    $display("MISMATCH at %0t: %s", $time, what);
  endtask

  task automatic check_reset_values();
    assert (!core_listen_port_valid && !core_open_conn_valid && !core_read_pkg_valid
            && !core_tx_meta_valid && !app_listen_status_valid && !app_open_status_valid
            && !app_rx_data_valid && !mem_rd_cmd_valid && !mem_wr_cmd_valid
            && !core_rd_data_valid) else flag_mismatch("valid output high in reset");
    assert (app_listen_port_ready && app_open_conn_ready && app_read_pkg_ready
            && app_tx_meta_ready && core_listen_status_ready && core_open_status_ready
            && core_rx_data_ready) else flag_mismatch("input ready low in reset");
    assert (rx_count == '0 && rd_cmd_count == '0 && rd_pkg_count == '0)
      else flag_mismatch("counters not zero in reset");
  endtask

  // checks see the values from before the edge and stimulus lands after it
  always @(posedge net_clk) begin
    if (net_aresetn) begin
      assert (core_rx_data_ready == (rx_occ != RX_BUFFER_DEPTH))
        else flag_mismatch("rx in_ready disagrees with occupancy");
      assert (app_rx_data_valid == (rx_occ != 0)) else flag_mismatch("rx out_valid");
      assert (rx_count == occ_h2) else flag_mismatch("rx_count not two cycles behind");
      if (core_rx_data_valid && core_rx_data_ready) begin
        rx_q.push_back(core_rx_data_beat);
      end
      if (app_rx_data_valid && app_rx_data_ready) begin
        assert (rx_q.size() != 0 && app_rx_data_beat == rx_q[0])
          else flag_mismatch("rx beat out of order");
        if (rx_q.size() != 0) begin
          void'(rx_q.pop_front());
        end
      end
      occ_h2 = occ_h1;
      occ_h1 = rx_occ;
      rx_occ = rx_q.size();
      if (!core_rx_data_ready) begin
        seen_full <= 1'b1;
      end
      // address from word[63:32] and length from word[22:0]
      assert (mem_rd_cmd_valid == core_rd_cmd_valid && core_rd_cmd_ready == mem_rd_cmd_ready
              && mem_rd_cmd_data == {32'd0, core_rd_cmd_data[63:32], 9'd0,
                                     core_rd_cmd_data[22:0]}) else flag_mismatch("rd command");
      assert (mem_wr_cmd_valid == core_wr_cmd_valid && core_wr_cmd_ready == mem_wr_cmd_ready
              && mem_wr_cmd_data == {32'd0, core_wr_cmd_data[63:32], 9'd0,
                                     core_wr_cmd_data[22:0]}) else flag_mismatch("wr command");
      assert (core_rd_data_valid == mem_rd_data_valid && mem_rd_data_ready == core_rd_data_ready
              && core_rd_data_beat == mem_rd_data_beat) else flag_mismatch("rd data path");
      assert (rd_cmd_count == rd_cmds && rd_pkg_count == rd_pkgs)
        else flag_mismatch("tx read counters");
      if (core_rd_cmd_valid && mem_rd_cmd_ready) begin
        rd_cmds = rd_cmds + 1'b1;
      end
      if (mem_rd_data_valid && core_rd_data_ready && mem_rd_data_beat.last) begin
        rd_pkgs = rd_pkgs + 1'b1;
      end
      if (!core_rx_data_valid || core_rx_data_ready) begin
        core_rx_data_valid <= run && ($urandom % 4 != 0);
        core_rx_data_beat  <= {{16{$urandom}}, {$urandom, $urandom}, 1'($urandom)};
      end
      app_rx_data_ready <= !run || (seen_full && $urandom % 2 == 0);  // fill first
      if (!core_rd_cmd_valid || mem_rd_cmd_ready) begin
        core_rd_cmd_valid <= run && ($urandom % 2 == 0);
        core_rd_cmd_data  <= CORE_CMD_WIDTH'({$urandom, $urandom, $urandom});
      end
      if (!core_wr_cmd_valid || mem_wr_cmd_ready) begin
        core_wr_cmd_valid <= run && ($urandom % 2 == 0);
        core_wr_cmd_data  <= CORE_CMD_WIDTH'({$urandom, $urandom, $urandom});
      end
      if (!mem_rd_data_valid || core_rd_data_ready) begin
        mem_rd_data_valid <= run && ($urandom % 3 != 0);
        mem_rd_data_beat  <= {{16{$urandom}}, {$urandom, $urandom}, 1'($urandom)};
      end
      mem_rd_cmd_ready   <= $urandom % 3 != 0;
      mem_wr_cmd_ready   <= $urandom % 3 != 0;
      core_rd_data_ready <= $urandom % 4 != 0;
    end
  end

  initial begin
    void'($urandom(32'hc17));
    net_aresetn        = 1'b0;
    run                = 1'b0;
    seen_full          = 1'b0;
    core_rx_data_valid = 1'b0;
    core_rx_data_beat  = '0;
    app_rx_data_ready  = 1'b0;
    core_rd_cmd_valid  = 1'b0;
    core_rd_cmd_data   = '0;
    core_wr_cmd_valid  = 1'b0;
    core_wr_cmd_data   = '0;
    mem_rd_cmd_ready   = 1'b0;
    mem_wr_cmd_ready   = 1'b0;
    mem_rd_data_valid  = 1'b0;
    mem_rd_data_beat   = '0;
    core_rd_data_ready = 1'b0;
    rd_cmds            = '0;
    rd_pkgs            = '0;
    value_errors       = 0;
    timeouts           = 0;
    repeat (8) @(posedge net_clk);
    check_reset_values();
    net_aresetn <= 1'b1;
    run         <= 1'b1;
    waited = 0;
    while (!seen_full && waited < 2000) begin  // buffer must reach depth
      @(negedge net_clk);
      waited++;
    end
    if (!seen_full) begin
      timeouts++;
      $display("ERROR at %0t: receive buffer never filled", $time);
    end
    repeat (3000) @(posedge net_clk);
    run <= 1'b0;
    repeat (2) @(negedge net_clk);  // last offered beats reach the scoreboards
    waited = 0;
    while ((rx_q.size() != 0 || slice_pend.sum() != 0) && waited < 1000) begin
      @(negedge net_clk);
      waited++;
    end
    if (rx_q.size() != 0 || slice_pend.sum() != 0) begin
      timeouts++;
      $display("ERROR at %0t: streams did not drain", $time);
    end
    $display("summary: %0d mismatches, %0d slice errors, %0d timeouts",
             value_errors, slice_err.sum(), timeouts);
    if (value_errors + slice_err.sum() + timeouts == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

/* files.f */
tcp_glue_pkg.sv
axis_reg_slice.sv
rx_buffer_fifo.sv
tx_mem_cmd_unit.sv
tcp_glue_top.sv
tb_tcp_glue.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_tcp_glue
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= *** TEST PASSED ***

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee /dev/stderr | grep -F '$(PASS_MSG)' > /dev/null

clean:
	rm -rf $(BUILD_DIR)
